//--- include/msoc_settings.svh
`ifndef MSOC_SETTINGS_SVH
`define MSOC_SETTINGS_SVH

// Bus geometry
`define MSOC_DATA_W   16       // Host data word
`define MSOC_ADDR_W   8        // Region nibble plus register nibble
`define MSOC_IDX_W    4        // Low address nibble selects the register

// Peripheral sizes
`define MSOC_PORT_W   8        // General-purpose port pins
`define MSOC_NUM_IRQ  5        // Two pins plus three timer events

// Identification block contents
`define MSOC_ID_CODE  16'h115a // Moscovium-SS core family code
`define MSOC_ID_VERS  16'h0148 // Release 1.48
`define MSOC_ID_FKHZ  24000    // System clock in kHz

`endif

//--- rtl/msoc_apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "msoc_settings.svh"

module msoc_apb_bridge import msoc_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  logic [`MSOC_ADDR_W-1:0] paddr_i,
	input  data_t                   pwdata_i,
	output data_t                   prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o,
	msoc_bus_if.bridge              intc_bus,
	msoc_bus_if.bridge              tim_bus,
	msoc_bus_if.bridge              gpio_bus
);

	brg_state_e state_q;
	region_e    rgn;
	reg_idx_t   idx;
	logic       stb;
	logic       err;
	data_t      id_rdata;
	data_t      sel_rdata;
	data_t      rdata_q;    // Read data held for the ready cycle
	logic       err_q;

	assign rgn = region_e'(paddr_i[`MSOC_ADDR_W-1:`MSOC_IDX_W]);  // Upper nibble
	assign idx = paddr_i[`MSOC_IDX_W-1:0];
	assign stb = psel_i & penable_i & (state_q == BRG_IDLE);     // First access cycle

	always_comb begin
		case (rgn)
			REG_ID:   err = pwrite_i;  // ID block is read only
			REG_INTC: err = 1'b0;
			REG_TIM:  err = 1'b0;
			REG_GPIO: err = 1'b0;
			default:  err = 1'b1;      // Hole in the map
		endcase
	end

	// Same request on all three buses, strobe only to the addressed one
	assign intc_bus.stb   = stb & (rgn == REG_INTC);
	assign intc_bus.we    = pwrite_i;
	assign intc_bus.idx   = idx;
	assign intc_bus.wdata = pwdata_i;
	assign tim_bus.stb    = stb & (rgn == REG_TIM);
	assign tim_bus.we     = pwrite_i;
	assign tim_bus.idx    = idx;
	assign tim_bus.wdata  = pwdata_i;
	assign gpio_bus.stb   = stb & (rgn == REG_GPIO);
	assign gpio_bus.we    = pwrite_i;
	assign gpio_bus.idx   = idx;
	assign gpio_bus.wdata = pwdata_i;

	always_comb begin
		case (idx)
			4'd0:    id_rdata = `MSOC_ID_CODE;
			4'd1:    id_rdata = `MSOC_ID_VERS;
			4'd2:    id_rdata = data_t'(`MSOC_ID_FKHZ);
			default: id_rdata = '0;
		endcase
	end

	always_comb begin
		case (rgn)
			REG_ID:   sel_rdata = err ? '0 : id_rdata;
			REG_INTC: sel_rdata = intc_bus.rdata;
			REG_TIM:  sel_rdata = tim_bus.rdata;
			REG_GPIO: sel_rdata = gpio_bus.rdata;
			default:  sel_rdata = '0;  // Unmapped reads as zero
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= BRG_IDLE;
			err_q   <= 1'b0;
		end else begin
			case (state_q)
				BRG_IDLE: begin
					if (stb) begin
						state_q <= BRG_RESP;  // Fixed single wait cycle
						err_q   <= err;
					end
				end
				BRG_RESP: state_q <= BRG_IDLE;
				default:  state_q <= BRG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (stb) begin
			rdata_q <= sel_rdata;  // Sampled with the strobe
		end
	end

	assign pready_o  = (state_q == BRG_RESP);
	assign pslverr_o = pready_o & err_q;
	assign prdata_o  = pready_o ? rdata_q : '0;  // Quiet bus outside the ready cycle

endmodule

`default_nettype wire

//--- rtl/msoc_gpio.sv
`timescale 1ns/1ps
`default_nettype none
`include "msoc_settings.svh"

module msoc_gpio import msoc_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	msoc_bus_if.periph  bus,
	input  port_t       port_in_i,
	output port_t       port_out_o,
	output port_t       port_oe_o
);

	port_t out_q;
	port_t oe_q;   // Set bit drives the pin
	port_t in_s1_q;
	port_t in_s2_q;
	logic  wr;

	assign wr = bus.stb & bus.we;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			out_q <= '0;
			oe_q  <= '0;  // All pins high impedance
		end else if (wr) begin
			case (bus.idx)
				GPIO_OUT: out_q <= bus.wdata[`MSOC_PORT_W-1:0];
				GPIO_OE:  oe_q  <= bus.wdata[`MSOC_PORT_W-1:0];
				default:  ;  // GPIO_IN is read only
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			in_s1_q <= '0;
			in_s2_q <= '0;
		end else begin
			in_s1_q <= port_in_i;  // Pins are asynchronous
			in_s2_q <= in_s1_q;
		end
	end

	assign port_out_o = out_q;
	assign port_oe_o  = oe_q;

	always_comb begin
		case (bus.idx)
			GPIO_OUT: bus.rdata = data_t'(out_q);
			GPIO_OE:  bus.rdata = data_t'(oe_q);
			GPIO_IN:  bus.rdata = data_t'(in_s2_q);
			default:  bus.rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/msoc_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Register access path from the bridge to one peripheral
interface msoc_bus_if import msoc_pkg::*; ();

	logic     stb;    // High for the first access cycle only
	logic     we;     // Write when set
	reg_idx_t idx;    // Register index
	data_t    wdata;
	data_t    rdata;  // Combinational from idx

	modport bridge (
		output stb,
		output we,
		output idx,
		output wdata,
		input  rdata
	);

	modport periph (
		input  stb,
		input  we,
		input  idx,
		input  wdata,
		output rdata
	);

endinterface

// Timer settings and live count between register block and counter
interface msoc_tim_if import msoc_pkg::*; ();

	logic  run;     // Counter enable
	data_t period;  // Wrap value
	data_t cmpa;    // Channel A threshold
	data_t cmpb;    // Channel B threshold
	data_t count;   // Current count

	modport regs (
		output run,
		output period,
		output cmpa,
		output cmpb,
		input  count
	);

	modport core (
		input  run,
		input  period,
		input  cmpa,
		input  cmpb,
		output count
	);

endinterface

`default_nettype wire

//--- rtl/msoc_intc.sv
`timescale 1ns/1ps
`default_nettype none
`include "msoc_settings.svh"

module msoc_intc import msoc_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	msoc_bus_if.periph  bus,
	input  logic        ext_int0_i,
	input  logic        ext_int1_i,
	input  logic        tim_ovf_i,
	input  logic        tim_cma_i,
	input  logic        tim_cmb_i,
	output logic        irq_o,
	output logic [3:0]  irq_vec_o
);

	logic [1:0] ext_s1_q;  // First synchronizer stage
	logic [1:0] ext_s2_q;  // Second synchronizer stage
	logic [1:0] ext_d_q;   // Previous synchronized level
	logic [1:0] ext_rise;
	irq_vec_t   src;
	irq_vec_t   clr;
	irq_vec_t   pend_q;
	irq_vec_t   enab_q;
	irq_vec_t   active;
	logic [3:0] vec;
	logic       wr_pend;
	logic       wr_enab;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ext_s1_q <= '0;
			ext_s2_q <= '0;
			ext_d_q  <= '0;
		end else begin
			ext_s1_q <= {ext_int1_i, ext_int0_i};
			ext_s2_q <= ext_s1_q;
			ext_d_q  <= ext_s2_q;
		end
	end

	assign ext_rise = ext_s2_q & ~ext_d_q;  // Rising edges only

	always_comb begin
		src           = '0;
		src[SRC_EXT0] = ext_rise[0];
		src[SRC_EXT1] = ext_rise[1];
		src[SRC_TOVF] = tim_ovf_i;  // Timer pulses are already one cycle
		src[SRC_TCMA] = tim_cma_i;
		src[SRC_TCMB] = tim_cmb_i;
	end

	assign wr_pend = bus.stb & bus.we & (bus.idx == INTC_PEND);
	assign wr_enab = bus.stb & bus.we & (bus.idx == INTC_ENAB);
	assign clr     = wr_pend ? bus.wdata[`MSOC_NUM_IRQ-1:0] : '0;
	assign active  = pend_q & enab_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pend_q <= '0;
			enab_q <= '0;
			irq_o  <= 1'b0;
		end else begin
			pend_q <= (pend_q & ~clr) | src;  // New event wins over clear
			if (wr_enab) begin
				enab_q <= bus.wdata[`MSOC_NUM_IRQ-1:0];
			end
			irq_o <= |active;
		end
	end

	// Lowest numbered active source has priority
	always_comb begin
		vec = 4'hf;
		for (int i = `MSOC_NUM_IRQ - 1; i >= 0; i--) begin
			if (active[i]) begin
				vec = 4'(i);
			end
		end
	end

	assign irq_vec_o = vec;

	always_comb begin
		case (bus.idx)
			INTC_PEND: bus.rdata = data_t'(pend_q);
			INTC_ENAB: bus.rdata = data_t'(enab_q);
			INTC_VECT: bus.rdata = data_t'(vec);
			default:   bus.rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/msoc_pkg.sv
`default_nettype none

package msoc_pkg;

	`include "msoc_settings.svh"

	typedef logic [`MSOC_DATA_W-1:0]  data_t;     // Bus word
	typedef logic [`MSOC_IDX_W-1:0]   reg_idx_t;  // Register index within a region
	typedef logic [`MSOC_PORT_W-1:0]  port_t;     // One port byte
	typedef logic [`MSOC_NUM_IRQ-1:0] irq_vec_t;  // One bit per interrupt source

	// Upper address nibble, other values unmapped
	typedef enum logic [`MSOC_ADDR_W-`MSOC_IDX_W-1:0] {
		REG_ID   = 4'h0,
		REG_INTC = 4'h1,
		REG_TIM  = 4'h2,
		REG_GPIO = 4'h3
	} region_e;

	typedef enum logic {
		BRG_IDLE = 1'b0,  // Waiting for an access phase
		BRG_RESP = 1'b1   // Ready cycle
	} brg_state_e;

	typedef enum logic [2:0] {
		SRC_EXT0 = 3'd0,
		SRC_EXT1 = 3'd1,
		SRC_TOVF = 3'd2,
		SRC_TCMA = 3'd3,
		SRC_TCMB = 3'd4
	} intc_src_e;

	typedef enum logic [`MSOC_IDX_W-1:0] {
		INTC_PEND = 4'd0,  // Write 1 to clear
		INTC_ENAB = 4'd1,
		INTC_VECT = 4'd2   // Read only
	} intc_reg_e;

	typedef enum logic [`MSOC_IDX_W-1:0] {
		TIM_CTRL = 4'd0,
		TIM_PERD = 4'd1,
		TIM_CMPA = 4'd2,
		TIM_CMPB = 4'd3,
		TIM_CNT  = 4'd4
	} tim_reg_e;

	typedef enum logic [`MSOC_IDX_W-1:0] {
		GPIO_OUT = 4'd0,
		GPIO_OE  = 4'd1,
		GPIO_IN  = 4'd2
	} gpio_reg_e;

endpackage

`default_nettype wire

//--- rtl/msoc_tim_core.sv
`timescale 1ns/1ps
`default_nettype none

module msoc_tim_core import msoc_pkg::*; (
	input  logic     clk,
	input  logic     rst_n_i,
	msoc_tim_if.core tim,
	input  logic     restart_i,
	output logic     tim_ovf_o,
	output logic     tim_cma_o,
	output logic     tim_cmb_o,
	output logic     tim_pwma_o,
	output logic     tim_pwmb_o
);

	data_t cnt_q;
	logic  at_top;  // Count sits on the period value

	assign at_top = (cnt_q == tim.period);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (restart_i) begin
			cnt_q <= '0;               // Period or count write
		end else if (tim.run) begin
			if (at_top) begin
				cnt_q <= '0;           // Wrap after period
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			tim_pwma_o <= 1'b0;
			tim_pwmb_o <= 1'b0;
		end else begin
			tim_pwma_o <= tim.run & (cnt_q < tim.cmpa);  // High for cmpa counts
			tim_pwmb_o <= tim.run & (cnt_q < tim.cmpb);
		end
	end

	// Event pulses last one count, silent while stopped
	assign tim_ovf_o = tim.run & at_top;
	assign tim_cma_o = tim.run & (cnt_q == tim.cmpa);
	assign tim_cmb_o = tim.run & (cnt_q == tim.cmpb);

	assign tim.count = cnt_q;

endmodule

`default_nettype wire

//--- rtl/msoc_tim_regs.sv
`timescale 1ns/1ps
`default_nettype none

module msoc_tim_regs import msoc_pkg::*; (
	input  logic        clk,
	input  logic        rst_n_i,
	msoc_bus_if.periph  bus,
	msoc_tim_if.regs    tim,
	output logic        restart_o
);

	logic  run_q;     // TIM_CTRL bit 0
	data_t period_q;
	data_t cmpa_q;
	data_t cmpb_q;
	logic  wr;

	assign wr = bus.stb & bus.we;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			run_q    <= 1'b0;
			period_q <= '0;
			cmpa_q   <= '0;
			cmpb_q   <= '0;
		end else if (wr) begin
			case (bus.idx)
				TIM_CTRL: run_q    <= bus.wdata[0];
				TIM_PERD: period_q <= bus.wdata;
				TIM_CMPA: cmpa_q   <= bus.wdata;
				TIM_CMPB: cmpb_q   <= bus.wdata;
				default:  ;  // TIM_CNT only restarts the core
			endcase
		end
	end

	// Count restarts from zero at the same edge as the write
	assign restart_o = wr & ((bus.idx == TIM_PERD) | (bus.idx == TIM_CNT));

	assign tim.run    = run_q;
	assign tim.period = period_q;
	assign tim.cmpa   = cmpa_q;
	assign tim.cmpb   = cmpb_q;

	always_comb begin
		case (bus.idx)
			TIM_CTRL: bus.rdata = data_t'(run_q);
			TIM_PERD: bus.rdata = period_q;
			TIM_CMPA: bus.rdata = cmpa_q;
			TIM_CMPB: bus.rdata = cmpb_q;
			TIM_CNT:  bus.rdata = tim.count;  // Live value from the core
			default:  bus.rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/msoc_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "msoc_settings.svh"

module msoc_top import msoc_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	input  logic                    pwrite_i,
	input  logic [`MSOC_ADDR_W-1:0] paddr_i,
	input  data_t                   pwdata_i,
	output data_t                   prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o,
	input  logic                    ext_int0_i,
	input  logic                    ext_int1_i,
	output logic                    irq_o,
	output logic [3:0]              irq_vec_o,
	output logic                    tim_pwma_o,
	output logic                    tim_pwmb_o,
	input  port_t                   port_in_i,
	output port_t                   port_out_o,
	output port_t                   port_oe_o
);

	logic tim_ovf;      // Timer events into the interrupt controller
	logic tim_cma;
	logic tim_cmb;
	logic tim_restart;  // Count reset request from the register block

	msoc_bus_if intc_bus ();
	msoc_bus_if tim_bus ();
	msoc_bus_if gpio_bus ();
	msoc_tim_if tim_if ();

	msoc_apb_bridge u_bridge (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.intc_bus  (intc_bus.bridge),
		.tim_bus   (tim_bus.bridge),
		.gpio_bus  (gpio_bus.bridge)
	);

	msoc_intc u_intc (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.bus        (intc_bus.periph),
		.ext_int0_i (ext_int0_i),
		.ext_int1_i (ext_int1_i),
		.tim_ovf_i  (tim_ovf),
		.tim_cma_i  (tim_cma),
		.tim_cmb_i  (tim_cmb),
		.irq_o      (irq_o),
		.irq_vec_o  (irq_vec_o)
	);

	msoc_tim_regs u_tim_regs (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.bus       (tim_bus.periph),
		.tim       (tim_if.regs),
		.restart_o (tim_restart)
	);

	msoc_tim_core u_tim_core (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.tim        (tim_if.core),
		.restart_i  (tim_restart),
		.tim_ovf_o  (tim_ovf),
		.tim_cma_o  (tim_cma),
		.tim_cmb_o  (tim_cmb),
		.tim_pwma_o (tim_pwma_o),
		.tim_pwmb_o (tim_pwmb_o)
	);

	msoc_gpio u_gpio (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.bus        (gpio_bus.periph),
		.port_in_i  (port_in_i),
		.port_out_o (port_out_o),
		.port_oe_o  (port_oe_o)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the msoc testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module msoc_tb -o msoc_sim \
	|| { echo "BUILD FAILED"; exit 1; }
./obj_dir/msoc_sim +verilator+error+limit+100 > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "Simulation failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Simulation completed successfully" sim.log && { echo "RESULT: PASS"; exit 0; }
echo "RESULT: FAIL (no result line in sim.log)"
exit 1

//--- src.f
+incdir+include
rtl/msoc_pkg.sv
rtl/msoc_ifs.sv
rtl/msoc_apb_bridge.sv
rtl/msoc_intc.sv
rtl/msoc_tim_regs.sv
rtl/msoc_tim_core.sv
rtl/msoc_gpio.sv
rtl/msoc_top.sv
verif/msoc_tb_chk.sv
verif/msoc_tb.sv

//--- verif/msoc_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "msoc_settings.svh"

module msoc_tb import msoc_pkg::*; ();

	localparam int MAX_CYCLES = 20000;  // Far above the test length
	localparam int PWM_P      = 9;      // Timer period, 10 cycles per PWM period
	localparam int PWM_A      = 3;
	localparam int PWM_B      = 6;
	localparam int PWM_K      = 4;      // Periods in the measuring window

	logic                    clk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [`MSOC_ADDR_W-1:0] paddr;
	data_t                   pwdata;
	data_t                   prdata;
	logic                    pready;
	logic                    pslverr;
	logic                    ext_int0;
	logic                    ext_int1;
	logic                    irq;
	logic [3:0]              irq_vec;
	logic                    pwma;
	logic                    pwmb;
	port_t                   port_in;
	port_t                   port_out;
	port_t                   port_oe;
	integer                  seed = 32'hfe5dedb7;
	int                      cycles = 0;

	msoc_top UUT (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.psel_i     (psel),
		.penable_i  (penable),
		.pwrite_i   (pwrite),
		.paddr_i    (paddr),
		.pwdata_i   (pwdata),
		.prdata_o   (prdata),
		.pready_o   (pready),
		.pslverr_o  (pslverr),
		.ext_int0_i (ext_int0),
		.ext_int1_i (ext_int1),
		.irq_o      (irq),
		.irq_vec_o  (irq_vec),
		.tim_pwma_o (pwma),
		.tim_pwmb_o (pwmb),
		.port_in_i  (port_in),
		.port_out_o (port_out),
		.port_oe_o  (port_oe)
	);

	always #2 clk = ~clk;  // 4 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			stop_run($sformatf("Timeout: no result after %0d cycles", cycles));
		end
	end

	always @(negedge clk) begin
		if (UUT.u_chk.fail_cnt != 0) begin
			stop_run("A bound assertion on the top level failed");
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_data(input string what, input data_t got, input data_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_port(input string what, input port_t got, input port_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_resp(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0t ns: %s pslverr_o %b, expected %b", $time, what,
				got, exp));
		end
	endtask

	// Both access cycles, shared by reads and writes
	task automatic run_access(output data_t rdata, output logic err);
		@(posedge clk);
		#1;
		penable = 1'b1;  // First access cycle
		@(negedge clk);
		check_bit("pready_o in first access cycle", pready, 1'b0);
		@(posedge clk);
		@(negedge clk);
		check_bit("pready_o in second access cycle", pready, 1'b1);
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;  // Back to idle
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [`MSOC_ADDR_W-1:0] addr, input data_t data,
		output logic err);
		data_t unused;
		@(posedge clk);
		#1;
		psel    = 1'b1;  // Setup cycle
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		run_access(unused, err);
	endtask

	task automatic apb_read(input logic [`MSOC_ADDR_W-1:0] addr, output data_t rdata,
		output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		run_access(rdata, err);
	endtask

	task automatic write_reg(input logic [`MSOC_ADDR_W-1:0] addr, input data_t data);
		logic err;
		apb_write(addr, data, err);
		check_resp($sformatf("write to %h", addr), err, 1'b0);
	endtask

	task automatic expect_read(input logic [`MSOC_ADDR_W-1:0] addr, input data_t exp,
		input string what);
		data_t rd;
		logic  err;
		apb_read(addr, rd, err);
		check_resp(what, err, 1'b0);
		check_data(what, rd, exp);
	endtask

	task automatic wait_irq(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (irq !== level) begin
			n++;
			if (n > limit) begin
				stop_run($sformatf("%s: irq_o did not reach %0b within %0d cycles", what,
					level, limit));
			end
			@(negedge clk);
		end
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_bit("pready_o after reset", pready, 1'b0);
		check_bit("pslverr_o after reset", pslverr, 1'b0);
		check_bit("irq_o after reset", irq, 1'b0);
		check_bit("tim_pwma_o after reset", pwma, 1'b0);
		check_bit("tim_pwmb_o after reset", pwmb, 1'b0);
		check_port("port_out_o after reset", port_out, 8'h00);
		check_port("port_oe_o after reset", port_oe, 8'h00);
		expect_read(8'h00, 16'h115a, "ID code");
		expect_read(8'h01, 16'h0148, "ID version");
		expect_read(8'h02, 16'd24000, "ID clock in kHz");
		expect_read(8'h03, 16'h0000, "ID index 3");
	endtask

	task automatic test_errors();
		data_t rd;
		logic  err;
		apb_read(8'h47, rd, err);  // Region 4 is a hole
		check_resp("read of region 4", err, 1'b1);
		check_data("read data of region 4", rd, 16'h0000);
		apb_read(8'hf3, rd, err);
		check_resp("read of region f", err, 1'b1);
		check_data("read data of region f", rd, 16'h0000);
		apb_write(8'h00, 16'hdead, err);
		check_resp("write to ID code", err, 1'b1);
		apb_write(8'h91, 16'h1234, err);
		check_resp("write to region 9", err, 1'b1);
		expect_read(8'h00, 16'h115a, "ID code after write");
		expect_read(8'h01, 16'h0148, "ID version after write");
	endtask

	task automatic test_gpio();
		port_t val;
		write_reg(8'h30, 16'h00a5);  // GPIO_OUT
		@(negedge clk);
		check_port("port_out_o", port_out, 8'ha5);
		write_reg(8'h31, 16'h003c);  // GPIO_OE
		@(negedge clk);
		check_port("port_oe_o", port_oe, 8'h3c);
		expect_read(8'h30, 16'h00a5, "GPIO_OUT readback");
		expect_read(8'h31, 16'h003c, "GPIO_OE readback");
		repeat (4) begin
			@(posedge clk);
			#1;
			val     = port_t'($random(seed));
			port_in = val;
			repeat (2) @(posedge clk);  // Two synchronizer stages
			expect_read(8'h32, data_t'(val), "GPIO_IN");
		end
	endtask

	task automatic wait_pwma_rise();
		int   n;
		logic last;
		n    = 0;
		last = 1'b1;
		@(negedge clk);
		while (!(last == 1'b0 && pwma == 1'b1)) begin
			last = pwma;
			n++;
			if (n > 4 * (PWM_P + 1)) begin
				stop_run("No rising edge on tim_pwma_o while the timer runs");
			end
			@(negedge clk);
		end
	endtask

	task automatic test_pwm();
		data_t rd;
		logic  err;
		logic  last_a;
		int    highs_a;
		int    highs_b;
		write_reg(8'h22, data_t'(PWM_A));  // TIM_CMPA
		write_reg(8'h23, data_t'(PWM_B));  // TIM_CMPB
		write_reg(8'h21, data_t'(PWM_P));  // Period write restarts the count
		write_reg(8'h20, 16'h0001);        // Run
		wait_pwma_rise();
		highs_a = 0;
		highs_b = 0;
		last_a  = 1'b0;
		repeat (PWM_K * (PWM_P + 1)) begin
			if (pwma) highs_a++;
			if (pwmb) highs_b++;
			last_a = pwma;
			@(negedge clk);
		end
		// Window must close exactly on a period boundary
		check_bit("tim_pwma_o at end of window", last_a, 1'b0);
		check_bit("tim_pwma_o after window", pwma, 1'b1);
		check_data("tim_pwma_o high cycles", data_t'(highs_a), data_t'(PWM_K * PWM_A));
		check_data("tim_pwmb_o high cycles", data_t'(highs_b), data_t'(PWM_K * PWM_B));
		apb_read(8'h24, rd, err);
		check_resp("TIM_CNT read", err, 1'b0);
		check_bit("TIM_CNT within period", rd <= data_t'(PWM_P), 1'b1);
		write_reg(8'h20, 16'h0000);        // Stop
		@(negedge clk);
		check_bit("tim_pwma_o after stop", pwma, 1'b0);
		check_bit("tim_pwmb_o after stop", pwmb, 1'b0);
	endtask

	task automatic test_irq();
		write_reg(8'h10, 16'h001f);  // Drop timer events left from the PWM run
		write_reg(8'h11, 16'h0001);  // Enable SRC_EXT0 only
		@(posedge clk);
		#1;
		ext_int0 = 1'b1;
		wait_irq(1'b1, 20, "ext_int0_i pulse");
		check_data("irq_vec_o for SRC_EXT0", data_t'(irq_vec), 16'h0000);
		@(posedge clk);
		#1;
		ext_int0 = 1'b0;  // End of the pin pulse
		expect_read(8'h10, 16'h0001, "INTC_PEND after ext_int0_i");
		expect_read(8'h12, 16'h0000, "INTC_VECT for SRC_EXT0");
		write_reg(8'h10, 16'h0001);  // Write 1 clears
		wait_irq(1'b0, 4, "pending clear");
		check_data("irq_vec_o with nothing pending", data_t'(irq_vec), 16'h000f);
		expect_read(8'h12, 16'h000f, "INTC_VECT with nothing pending");
		write_reg(8'h11, 16'h0004);  // SRC_TOVF only
		write_reg(8'h20, 16'h0001);  // Timer keeps the PWM period
		wait_irq(1'b1, 4 * (PWM_P + 1), "timer overflow");
		check_data("irq_vec_o for SRC_TOVF", data_t'(irq_vec), 16'h0002);
		expect_read(8'h12, 16'h0002, "INTC_VECT for SRC_TOVF");
		write_reg(8'h20, 16'h0000);
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		ext_int0 = 1'b0;
		ext_int1 = 1'b0;
		port_in  = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_errors();
		test_gpio();
		test_pwm();
		test_irq();
		repeat (4) @(posedge clk);
		if (UUT.u_chk.fail_cnt != 0) begin
			stop_run("A bound assertion on the top level failed");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verif/msoc_tb_chk.sv
`timescale 1ns/1ps
`default_nettype none

module msoc_tb_chk import msoc_pkg::*; (
	input logic     clk,
	input logic     rst_n_i,
	input logic     psel_i,
	input logic     penable_i,
	input logic     pready_i,
	input logic     pslverr_i,
	input logic     irq_i,
	input irq_vec_t enab_i,   // Interrupt enable register
	input logic     run_i,    // Timer run bit
	input logic     pwma_i,
	input logic     pwmb_i
);

	int fail_cnt = 0;  // Failed assertions so far

	ready_in_access: assert property (@(posedge clk) disable iff (!rst_n_i)
		pready_i |-> (psel_i && penable_i))
		else begin
			$error("pready_o high outside an APB access");
			fail_cnt++;
		end

	ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		pready_i |=> !pready_i)
		else begin
			$error("pready_o held for more than one cycle");
			fail_cnt++;
		end

	err_with_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
		pslverr_i |-> pready_i)
		else begin
			$error("pslverr_o high without pready_o");
			fail_cnt++;
		end

	// irq_o is registered, so it follows the enable one cycle late
	irq_needs_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
		($past(enab_i) == '0) |-> !irq_i)
		else begin
			$error("irq_o high with all sources disabled");
			fail_cnt++;
		end

	pwm_low_stopped: assert property (@(posedge clk) disable iff (!rst_n_i)
		!$past(run_i) |-> !(pwma_i || pwmb_i))
		else begin
			$error("PWM output high while the timer is stopped");
			fail_cnt++;
		end

endmodule

bind msoc_top msoc_tb_chk u_chk (
	.clk       (clk),
	.rst_n_i   (rst_n_i),
	.psel_i    (psel_i),
	.penable_i (penable_i),
	.pready_i  (pready_o),
	.pslverr_i (pslverr_o),
	.irq_i     (irq_o),
	.enab_i    (u_intc.enab_q),
	.run_i     (tim_if.run),
	.pwma_i    (tim_pwma_o),
	.pwmb_i    (tim_pwmb_o)
);

`default_nettype wire
